// ==== bram_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bram_port_if #(
    parameter int AW = 3,
    parameter int DW = 32
);

    logic          ce;
    logic          we;
    logic [AW-1:0] addr;
    logic [DW-1:0] d;
    logic [DW-1:0] q;

    // Engine side
    modport ctrl (output ce, we, addr, d, input q);
    // RAM side
    modport mem (input ce, we, addr, d, output q);

endinterface

`default_nettype wire

// ==== gemm.f ====
gemm_pkg.sv
bram_port_if.sv
true_dpbram.sv
gemm_ctrl.sv
mac_lane_array.sv
ofmap_requant.sv
gemm_top.sv
gemm_sva.sv
tb_gemm.sv

// ==== gemm_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gemm_ctrl import gemm_pkg::*; #(
    parameter int PE_SIZE = 4,
    parameter int ROW_NUM = 8
) (
    input  wire logic                        clk,
    input  wire logic                        reset_i,
    input  wire logic                        start_i,
    bram_port_if.ctrl                        ifm_port,
    bram_port_if.ctrl                        wgt_port,
    bram_port_if.ctrl                        ofm_port,
    output lane_op_e                         lane_op_o,
    output logic      [$clog2(PE_SIZE)-1:0]  elem_sel_o,
    output logic                             finish_o
);

    localparam int ROW_AW = $clog2(ROW_NUM);
    localparam int K_AW   = $clog2(PE_SIZE);

    gemm_state_e       state_q;
    gemm_state_e       state_d;
    logic [ROW_AW-1:0] row_q;
    logic [K_AW-1:0]   k_q;
    logic              row_last;
    logic              k_last;

    assign row_last = (row_q == ROW_AW'(ROW_NUM - 1));
    assign k_last   = (k_q == K_AW'(PE_SIZE - 1));

    // ----------------------------------------
    // Next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (start_i) state_d = FETCH_ROW;
            FETCH_ROW: state_d = MAC;
            MAC:       if (k_last) state_d = DRAIN;
            DRAIN:     state_d = WRITE;
            WRITE:     state_d = row_last ? DONE : FETCH_ROW;
            DONE:      state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    // ----------------------------------------
    // State, counters and lane pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= IDLE;
            row_q      <= '0;
            k_q        <= '0;
            lane_op_o  <= LANE_HOLD;
            elem_sel_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == MAC) begin
                k_q <= k_last ? '0 : k_q + 1'b1;
            end else begin
                k_q <= '0;
            end
            if (state_q == WRITE) begin
                row_q <= row_last ? '0 : row_q + 1'b1;
            end
            // Weight data lands one cycle after its read, so opcode and index lag k
            if (state_q == MAC) begin
                lane_op_o <= (k_q == '0) ? LANE_LOAD : LANE_ACC;
            end else begin
                lane_op_o <= LANE_HOLD;
            end
            elem_sel_o <= k_q;
        end
    end

    // RAM strobes decode straight from the state
    assign ifm_port.ce   = (state_q == FETCH_ROW);
    assign ifm_port.we   = 1'b0;
    assign ifm_port.addr = row_q;
    assign ifm_port.d    = '0;

    assign wgt_port.ce   = (state_q == MAC);
    assign wgt_port.we   = 1'b0;
    assign wgt_port.addr = k_q;
    assign wgt_port.d    = '0;

    // Ofmap data comes from the requant block
    assign ofm_port.ce   = (state_q == WRITE);
    assign ofm_port.we   = (state_q == WRITE);
    assign ofm_port.addr = row_q;

    assign finish_o = (state_q == DONE);

endmodule

`default_nettype wire

// ==== gemm_pkg.sv ====
`default_nettype none

package gemm_pkg;

    // ----------------------------------------
    // Data widths
    // ----------------------------------------
    // Signed element width of A, B and the ofmap
    localparam int DATA_WIDTH = 8;
    // Signed accumulator width per lane
    localparam int PSUM_WIDTH = 32;

    // ----------------------------------------
    // Controller states
    // ----------------------------------------
    typedef enum logic [2:0] {
        IDLE,
        FETCH_ROW,
        MAC,
        DRAIN,
        WRITE,
        DONE
    } gemm_state_e;

    // Lane opcodes where LOAD replaces the sum with the first product
    typedef enum logic [1:0] {
        LANE_HOLD,
        LANE_LOAD,
        LANE_ACC
    } lane_op_e;

endpackage

`default_nettype wire

// ==== gemm_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module gemm_sva import gemm_pkg::*; (
    input wire logic        clk,
    input wire logic        reset_i,
    input wire logic        start_i,
    input wire gemm_state_e state_q,
    input wire logic        finish_o,
    input wire logic        ifm_ce,
    input wire logic        wgt_ce,
    input wire logic        ofm_ce,
    input wire logic        ofm_we
);

    // One-cycle finish pulse
    assert property (@(posedge clk) disable iff (reset_i) finish_o |=> !finish_o)
        else $error("finish_o held longer than one cycle");

    // Row write follows the drain cycle
    assert property (@(posedge clk) disable iff (reset_i)
        (ofm_ce && ofm_we) |-> $past(state_q) == DRAIN)
        else $error("ofmap write not right after DRAIN");

    // RAM port 0 stays quiet while idle without start
    assert property (@(posedge clk) disable iff (reset_i)
        (state_q == IDLE && !start_i) |=> !(ifm_ce || wgt_ce || ofm_ce))
        else $error("RAM strobe high after IDLE without start");

endmodule

bind gemm_ctrl gemm_sva u_sva (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (start_i),
    .state_q  (state_q),
    .finish_o (finish_o),
    .ifm_ce   (ifm_port.ce),
    .wgt_ce   (wgt_port.ce),
    .ofm_ce   (ofm_port.ce),
    .ofm_we   (ofm_port.we)
);

`default_nettype wire

// ==== gemm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gemm_top import gemm_pkg::*; #(
    parameter int PE_SIZE   = 4,
    parameter int ROW_NUM   = 8,
    parameter int OUT_SHIFT = 4
) (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               start_i,
    output logic                                    finish_o,
    input  wire logic                               ifm_ce_i,
    input  wire logic                               ifm_we_i,
    input  wire logic [$clog2(ROW_NUM)-1:0]         ifm_addr_i,
    input  wire logic [PE_SIZE*DATA_WIDTH-1:0]      ifm_d_i,
    input  wire logic                               wgt_ce_i,
    input  wire logic                               wgt_we_i,
    input  wire logic [$clog2(PE_SIZE)-1:0]         wgt_addr_i,
    input  wire logic [PE_SIZE*DATA_WIDTH-1:0]      wgt_d_i,
    input  wire logic                               ofm_ce_i,
    input  wire logic [$clog2(ROW_NUM)-1:0]         ofm_addr_i,
    output logic      [PE_SIZE*DATA_WIDTH-1:0]      ofm_q_o
);

    localparam int WORD_W = PE_SIZE * DATA_WIDTH;
    localparam int ROW_AW = $clog2(ROW_NUM);
    localparam int K_AW   = $clog2(PE_SIZE);

    lane_op_e                    lane_op_w;
    logic [K_AW-1:0]             elem_sel_w;
    logic signed [PSUM_WIDTH-1:0] psum_w [PE_SIZE];

    bram_port_if #(.AW(ROW_AW), .DW(WORD_W)) ifm_port ();
    bram_port_if #(.AW(K_AW),   .DW(WORD_W)) wgt_port ();
    bram_port_if #(.AW(ROW_AW), .DW(WORD_W)) ofm_port ();

    // ----------------------------------------
    // RAMs with port 1 on the testbench side
    // ----------------------------------------
    true_dpbram #(.DWIDTH(WORD_W), .DEPTH(ROW_NUM)) u_ifm_ram (
        .clk     (clk),
        .port0   (ifm_port.mem),
        .addr1_i (ifm_addr_i),
        .ce1_i   (ifm_ce_i),
        .we1_i   (ifm_we_i),
        .d1_i    (ifm_d_i),
        .q1_o    ()
    );

    true_dpbram #(.DWIDTH(WORD_W), .DEPTH(PE_SIZE)) u_wgt_ram (
        .clk     (clk),
        .port0   (wgt_port.mem),
        .addr1_i (wgt_addr_i),
        .ce1_i   (wgt_ce_i),
        .we1_i   (wgt_we_i),
        .d1_i    (wgt_d_i),
        .q1_o    ()
    );

    // Readback only on port 1
    true_dpbram #(.DWIDTH(WORD_W), .DEPTH(ROW_NUM)) u_ofm_ram (
        .clk     (clk),
        .port0   (ofm_port.mem),
        .addr1_i (ofm_addr_i),
        .ce1_i   (ofm_ce_i),
        .we1_i   (1'b0),
        .d1_i    ('0),
        .q1_o    (ofm_q_o)
    );

    // ----------------------------------------
    // Engine
    // ----------------------------------------
    gemm_ctrl #(.PE_SIZE(PE_SIZE), .ROW_NUM(ROW_NUM)) u_ctrl (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .ifm_port   (ifm_port.ctrl),
        .wgt_port   (wgt_port.ctrl),
        .ofm_port   (ofm_port.ctrl),
        .lane_op_o  (lane_op_w),
        .elem_sel_o (elem_sel_w),
        .finish_o   (finish_o)
    );

    mac_lane_array #(.PE_SIZE(PE_SIZE)) u_lanes (
        .clk           (clk),
        .reset_i       (reset_i),
        .lane_op_i     (lane_op_w),
        .elem_sel_i    (elem_sel_w),
        .ifmap_word_i  (ifm_port.q),
        .weight_word_i (wgt_port.q),
        .psum_o        (psum_w)
    );

    ofmap_requant #(.PE_SIZE(PE_SIZE), .OUT_SHIFT(OUT_SHIFT)) u_requant (
        .psum_i       (psum_w),
        .ofmap_word_o (ofm_port.d)
    );

endmodule

`default_nettype wire

// ==== mac_lane_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_lane_array import gemm_pkg::*; #(
    parameter int PE_SIZE = 4
) (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire lane_op_e                           lane_op_i,
    input  wire logic [$clog2(PE_SIZE)-1:0]         elem_sel_i,
    input  wire logic [PE_SIZE*DATA_WIDTH-1:0]      ifmap_word_i,
    input  wire logic [PE_SIZE*DATA_WIDTH-1:0]      weight_word_i,
    output logic signed [PSUM_WIDTH-1:0]            psum_o [PE_SIZE]
);

    logic        [PE_SIZE*DATA_WIDTH-1:0] a_row_q;
    logic signed [DATA_WIDTH-1:0]         a_elem;

    // Row register tracks the RAM output while lanes idle,
    // so it holds the new A row when the first LOAD arrives
    always_ff @(posedge clk) begin
        if (lane_op_i == LANE_HOLD) begin
            a_row_q <= ifmap_word_i;
        end
    end

    // Element 0 sits in the top byte
    assign a_elem = signed'(a_row_q[(PE_SIZE - 1 - int'(elem_sel_i)) * DATA_WIDTH +: DATA_WIDTH]);

    // ----------------------------------------
    // Lanes
    // ----------------------------------------
    for (genvar n = 0; n < PE_SIZE; n++) begin : g_lane
        logic signed [DATA_WIDTH-1:0]   w_elem;
        logic signed [2*DATA_WIDTH-1:0] prod;

        assign w_elem = signed'(weight_word_i[(PE_SIZE - 1 - n) * DATA_WIDTH +: DATA_WIDTH]);
        assign prod   = a_elem * w_elem;

        always_ff @(posedge clk) begin
            if (reset_i) begin
                psum_o[n] <= '0;
            end else begin
                case (lane_op_i)
                    LANE_LOAD: psum_o[n] <= prod;
                    LANE_ACC:  psum_o[n] <= psum_o[n] + prod;
                    default:   psum_o[n] <= psum_o[n];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== ofmap_requant.sv ====
`timescale 1ns/1ps
`default_nettype none

module ofmap_requant import gemm_pkg::*; #(
    parameter int PE_SIZE   = 4,
    parameter int OUT_SHIFT = 4
) (
    input  wire logic signed [PSUM_WIDTH-1:0]  psum_i [PE_SIZE],
    output logic [PE_SIZE*DATA_WIDTH-1:0]      ofmap_word_o
);

    // Signed 8-bit output range
    localparam logic signed [PSUM_WIDTH-1:0] SAT_MAX = PSUM_WIDTH'(2 ** (DATA_WIDTH - 1) - 1);
    localparam logic signed [PSUM_WIDTH-1:0] SAT_MIN = -PSUM_WIDTH'(2 ** (DATA_WIDTH - 1));

    for (genvar n = 0; n < PE_SIZE; n++) begin : g_requant
        logic signed [PSUM_WIDTH-1:0] shifted;
        logic        [DATA_WIDTH-1:0] clamped;

        // Arithmetic shift keeps the sign
        assign shifted = psum_i[n] >>> OUT_SHIFT;

        always_comb begin
            if (shifted > SAT_MAX) begin
                clamped = SAT_MAX[DATA_WIDTH-1:0];
            end else if (shifted < SAT_MIN) begin
                clamped = SAT_MIN[DATA_WIDTH-1:0];
            end else begin
                clamped = shifted[DATA_WIDTH-1:0];
            end
        end

        // Lane 0 in the top byte
        assign ofmap_word_o[(PE_SIZE - 1 - n) * DATA_WIDTH +: DATA_WIDTH] = clamped;
    end

endmodule

`default_nettype wire

// ==== run_gemm.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_gemm -f gemm.f

sim_status=0
./obj_dir/Vtb_gemm > run_gemm.log 2>&1 || sim_status=$?
cat run_gemm.log

if grep -q "SOME TESTS FAILED" run_gemm.log || [ "$sim_status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== tb_gemm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gemm import gemm_pkg::*;;

    localparam int PE_SIZE   = 4;
    localparam int ROW_NUM   = 8;
    localparam int OUT_SHIFT = 4;
    localparam int WORD_W    = PE_SIZE * DATA_WIDTH;
    localparam int ROW_AW    = $clog2(ROW_NUM);
    localparam int K_AW      = $clog2(PE_SIZE);

    // Cycles from start to the finish pulse, and per-run load plus readback
    localparam int RUN_CYCLES     = ROW_NUM * (PE_SIZE + 3) + 1;
    localparam int IO_CYCLES      = 2 * ROW_NUM + 4;
    localparam int TIMEOUT_CYCLES = 4 * (RUN_CYCLES + IO_CYCLES) + 200;

    logic              clk;
    logic              reset_i;
    logic              start_i;
    logic              finish_o;
    logic              ifm_ce_i;
    logic              ifm_we_i;
    logic [ROW_AW-1:0] ifm_addr_i;
    logic [WORD_W-1:0] ifm_d_i;
    logic              wgt_ce_i;
    logic              wgt_we_i;
    logic [K_AW-1:0]   wgt_addr_i;
    logic [WORD_W-1:0] wgt_d_i;
    logic              ofm_ce_i;
    logic [ROW_AW-1:0] ofm_addr_i;
    logic [WORD_W-1:0] ofm_q_o;

    int a_mat [ROW_NUM][PE_SIZE];
    int b_mat [PE_SIZE][PE_SIZE];
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    gemm_top #(.PE_SIZE(PE_SIZE), .ROW_NUM(ROW_NUM), .OUT_SHIFT(OUT_SHIFT)) u_dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .finish_o   (finish_o),
        .ifm_ce_i   (ifm_ce_i),
        .ifm_we_i   (ifm_we_i),
        .ifm_addr_i (ifm_addr_i),
        .ifm_d_i    (ifm_d_i),
        .wgt_ce_i   (wgt_ce_i),
        .wgt_we_i   (wgt_we_i),
        .wgt_addr_i (wgt_addr_i),
        .wgt_d_i    (wgt_d_i),
        .ofm_ce_i   (ofm_ce_i),
        .ofm_addr_i (ofm_addr_i),
        .ofm_q_o    (ofm_q_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Hard limit on the whole run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [DATA_WIDTH-1:0] expected_elem(input int m, input int n);
        int sum;
        int shifted;
        sum = 0;
        for (int k = 0; k < PE_SIZE; k++) begin
            sum += a_mat[m][k] * b_mat[k][n];
        end
        shifted = sum >>> OUT_SHIFT;
        if (shifted > 127) shifted = 127;
        if (shifted < -128) shifted = -128;
        return DATA_WIDTH'(shifted);
    endfunction

    // Element 0 goes to the most significant byte
    function automatic logic [WORD_W-1:0] expected_row(input int m);
        logic [WORD_W-1:0] word;
        for (int n = 0; n < PE_SIZE; n++) begin
            word[(PE_SIZE - 1 - n) * DATA_WIDTH +: DATA_WIDTH] = expected_elem(m, n);
        end
        return word;
    endfunction

    function automatic logic [WORD_W-1:0] pack_a_row(input int m);
        logic [WORD_W-1:0] word;
        for (int k = 0; k < PE_SIZE; k++) begin
            word[(PE_SIZE - 1 - k) * DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(a_mat[m][k]);
        end
        return word;
    endfunction

    function automatic logic [WORD_W-1:0] pack_b_row(input int k);
        logic [WORD_W-1:0] word;
        for (int n = 0; n < PE_SIZE; n++) begin
            word[(PE_SIZE - 1 - n) * DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(b_mat[k][n]);
        end
        return word;
    endfunction

    function automatic int rand_elem(input bit extreme);
        if (extreme) begin
            return ($urandom % 2 == 0) ? -128 : 127;
        end
        return int'($urandom % 32) - 16;
    endfunction

    // Fill both matrices, then write them through port 1
    task automatic load_mats(input bit extreme);
        for (int m = 0; m < ROW_NUM; m++) begin
            for (int k = 0; k < PE_SIZE; k++) begin
                a_mat[m][k] = rand_elem(extreme);
            end
        end
        for (int k = 0; k < PE_SIZE; k++) begin
            for (int n = 0; n < PE_SIZE; n++) begin
                b_mat[k][n] = rand_elem(extreme);
            end
        end
        if (extreme) begin
            // Force saturation in both directions
            for (int k = 0; k < PE_SIZE; k++) begin
                a_mat[0][k] = 127;
                a_mat[1][k] = -128;
                b_mat[k][0] = 127;
                b_mat[k][1] = -128;
            end
        end
        for (int r = 0; r < ROW_NUM; r++) begin
            @(negedge clk);
            ifm_ce_i   = 1'b1;
            ifm_we_i   = 1'b1;
            ifm_addr_i = ROW_AW'(r);
            ifm_d_i    = pack_a_row(r);
            wgt_ce_i   = (r < PE_SIZE);
            wgt_we_i   = (r < PE_SIZE);
            wgt_addr_i = K_AW'(r % PE_SIZE);
            wgt_d_i    = pack_b_row(r % PE_SIZE);
        end
        @(negedge clk);
        ifm_ce_i = 1'b0;
        ifm_we_i = 1'b0;
        wgt_ce_i = 1'b0;
        wgt_we_i = 1'b0;
    endtask

    // Start, wait for finish_o, then read every ofmap row back
    task automatic run_gemm(input bit second_start);
        int cycles;
        logic [WORD_W-1:0] got;
        cycles = 0;
        @(negedge clk);
        start_i = 1'b1;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            // Extra start pulse mid-run
            start_i = second_start && (cycles == 10);
        end while (!finish_o && cycles < 2 * RUN_CYCLES);
        if (!finish_o) begin
            $display("finish_o did not arrive within %0d cycles of start", 2 * RUN_CYCLES);
            error_count++;
        end else begin
            check_val("finish_o latency", 64'(cycles), 64'(RUN_CYCLES));
        end
        ofm_ce_i   = 1'b1;
        ofm_addr_i = '0;
        for (int r = 0; r < ROW_NUM; r++) begin
            @(negedge clk);
            got = ofm_q_o;
            if (r + 1 < ROW_NUM) begin
                ofm_addr_i = ROW_AW'(r + 1);
            end else begin
                ofm_ce_i = 1'b0;
            end
            check_val($sformatf("ofm_q_o row %0d", r), 64'(got), 64'(expected_row(r)));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h72f3_bd35));
        reset_i    = 1'b1;
        start_i    = 1'b0;
        ifm_ce_i   = 1'b0;
        ifm_we_i   = 1'b0;
        ifm_addr_i = '0;
        ifm_d_i    = '0;
        wgt_ce_i   = 1'b0;
        wgt_we_i   = 1'b0;
        wgt_addr_i = '0;
        wgt_d_i    = '0;
        ofm_ce_i   = 1'b0;
        ofm_addr_i = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // Idle with no start
        repeat (8) begin
            @(negedge clk);
            check_val("finish_o idle", 64'(finish_o), 64'(0));
        end

        load_mats(1'b0);
        run_gemm(1'b0);
        load_mats(1'b1);
        run_gemm(1'b0);
        // New data without reset
        load_mats(1'b0);
        run_gemm(1'b0);
        load_mats(1'b0);
        run_gemm(1'b1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== true_dpbram.sv ====
`timescale 1ns/1ps
`default_nettype none

module true_dpbram #(
    parameter int DWIDTH = 32,
    parameter int DEPTH  = 8
) (
    input  wire logic                      clk,
    bram_port_if.mem                       port0,
    input  wire logic [$clog2(DEPTH)-1:0]  addr1_i,
    input  wire logic                      ce1_i,
    input  wire logic                      we1_i,
    input  wire logic [DWIDTH-1:0]         d1_i,
    output logic      [DWIDTH-1:0]         q1_o
);

    logic [DWIDTH-1:0] mem [DEPTH];
    logic [DWIDTH-1:0] q0_q;

    // Both ports share one clock and register their read data
    always_ff @(posedge clk) begin
        if (port0.ce) begin
            if (port0.we) begin
                mem[port0.addr] <= port0.d;
            end else begin
                q0_q <= mem[port0.addr];
            end
        end
        if (ce1_i) begin
            if (we1_i) begin
                mem[addr1_i] <= d1_i;
            end else begin
                q1_o <= mem[addr1_i];
            end
        end
    end

    assign port0.q = q0_q;

endmodule

`default_nettype wire
